// ==== Bender.yml ====
package:
  name: cpu_mem_interface

sources:
  - mem_map_pkg.sv
  - mem_port_if.sv
  - dmem_decoder.sv
  - data_ram.sv
  - loader_ram.sv
  - text_write_sequencer.sv
  - text_ram.sv
  - cpu_mem_interface.sv
  - target: test
    files:
      - cpu_mem_interface_checker.sv
      - tb_cpu_mem_interface.sv

// ==== cpu_mem_interface.f ====
mem_map_pkg.sv
mem_port_if.sv
dmem_decoder.sv
data_ram.sv
loader_ram.sv
text_write_sequencer.sv
text_ram.sv
cpu_mem_interface.sv
cpu_mem_interface_checker.sv
tb_cpu_mem_interface.sv

// ==== cpu_mem_interface.sv ====
`timescale 1ns/1ps

module cpu_mem_interface #(
    parameter int DATA_AW   = 10,
    parameter int LOADER_AW = 10,
    parameter int TEXT_AW   = 12
) (
    input  logic                    text_mem_clk,
    input  logic                    rst_n,
    input  mem_map_pkg::word_addr_t instr_addr,
    input  logic                    dmem_read,
    input  logic                    dmem_write,
    input  mem_map_pkg::word_addr_t dmem_addr,
    input  mem_map_pkg::data_word_t dmem_wdata,
    input  mem_map_pkg::byte_en_t   dmem_byte_en,
    input  mem_map_pkg::word_addr_t loader_addr,
    input  logic [TEXT_AW-1:0]      scan_addr,
    output mem_map_pkg::data_word_t instr_rdata,
    output mem_map_pkg::data_word_t dmem_rdata,
    output logic                    mem_stall,
    output mem_map_pkg::data_word_t loader_rdata,
    output mem_map_pkg::char_t      scan_char
);

    //////////////////////////////////////////////////////////////////////
    // internal wiring
    //////////////////////////////////////////////////////////////////////

    mem_port_if dport_data ();
    mem_port_if dport_loader ();

    // fetch words from both ram instruction ports
    mem_map_pkg::data_word_t instr_rdata_data;
    mem_map_pkg::data_word_t instr_rdata_loader;

    logic                    text_req;
    logic [TEXT_AW-1:0]      text_addr;
    mem_map_pkg::char_t      text_char;
    logic                    text_wen;

    dmem_decoder u_decoder (
        .text_mem_clk       (text_mem_clk),
        .rst_n              (rst_n),
        .instr_addr         (instr_addr),
        .dmem_read          (dmem_read),
        .dmem_write         (dmem_write),
        .dmem_addr          (dmem_addr),
        .dmem_wdata         (dmem_wdata),
        .dmem_byte_en       (dmem_byte_en),
        .loader_addr        (loader_addr),
        .instr_rdata_data   (instr_rdata_data),
        .instr_rdata_loader (instr_rdata_loader),
        .text_req           (text_req),
        .dport_data         (dport_data.master),
        .dport_loader       (dport_loader.master),
        .instr_rdata        (instr_rdata),
        .dmem_rdata         (dmem_rdata),
        .loader_rdata       (loader_rdata),
        .loader_addr_sel    (),
        .instr_loader_sel   ()
    );

    // main memory, stands in for the cached ddr path
    data_ram #(
        .DATA_AW (DATA_AW)
    ) u_data_ram (
        .text_mem_clk (text_mem_clk),
        .dport        (dport_data.target),
        .instr_addr   (instr_addr),
        .instr_rdata  (instr_rdata_data)
    );

    loader_ram #(
        .LOADER_AW (LOADER_AW)
    ) u_loader_ram (
        .text_mem_clk (text_mem_clk),
        .dport        (dport_loader.target),
        .instr_addr   (instr_addr),
        .instr_rdata  (instr_rdata_loader)
    );

    //////////////////////////////////////////////////////////////////////
    // text memory path
    //////////////////////////////////////////////////////////////////////

    text_write_sequencer #(
        .TEXT_AW (TEXT_AW)
    ) u_text_seq (
        .text_mem_clk (text_mem_clk),
        .rst_n        (rst_n),
        .text_req     (text_req),
        .dmem_addr    (dmem_addr),
        .dmem_byte_en (dmem_byte_en),
        .dmem_wdata   (dmem_wdata),
        .mem_stall    (mem_stall),
        .text_addr    (text_addr),
        .text_char    (text_char),
        .text_wen     (text_wen)
    );

    text_ram #(
        .TEXT_AW (TEXT_AW)
    ) u_text_ram (
        .text_mem_clk (text_mem_clk),
        .text_addr    (text_addr),
        .text_char    (text_char),
        .text_wen     (text_wen),
        .scan_addr    (scan_addr),
        .scan_char    (scan_char)
    );

endmodule

// ==== cpu_mem_interface_checker.sv ====
`timescale 1ns/1ps

module cpu_mem_interface_checker (
    input logic text_mem_clk,
    input logic rst_n,
    input logic mem_stall,
    input logic text_wen
);

    // assertion failures so far
    int unsigned fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // text write and stall rules
    //////////////////////////////////////////////////////////////////////

    // write enable only follows a stalled cycle
    wen_after_stall: assert property (
        @(posedge text_mem_clk) disable iff (!rst_n)
        text_wen |-> $past(mem_stall)
    ) else begin
        fail_count = fail_count + 1;
        $error("text_wen high without mem_stall on the previous cycle");
    end

    // three stall cycles at most
    stall_max_three: assert property (
        @(posedge text_mem_clk) disable iff (!rst_n)
        mem_stall [*3] |=> !mem_stall
    ) else begin
        fail_count = fail_count + 1;
        $error("mem_stall held for more than three cycles");
    end

endmodule

bind cpu_mem_interface cpu_mem_interface_checker u_checker (
    .text_mem_clk (text_mem_clk),
    .rst_n        (rst_n),
    .mem_stall    (mem_stall),
    .text_wen     (text_wen)
);

// ==== cpu_mem_trace.txt ====
// op_addr_data_be_expected, hex; op 1 write, 2 read, 3 fetch, 4 text write,
// 5 scan, 6 external loader read, 0 end; op 4 expects the stall length
1_00000010_11223344_f_00000000
1_00000010_aabbccdd_8_00000000
2_00000010_00000000_0_112233dd
1_00000010_55667788_2_00000000
1_00000010_99aabbcc_5_00000000
2_00000010_00000000_0_9966bbdd
1_00000024_deadbeef_f_00000000
1_00000024_0000ff00_3_00000000
2_00000024_00000000_0_0000beef
2_2c000024_00000000_0_0000beef
1_3c000008_cafe0001_f_00000000
2_3c000008_00000000_0_cafe0001
3_3c000008_00000000_0_cafe0001
3_00000010_00000000_0_9966bbdd
1_3c000009_0badf00d_f_00000000
3_3c000009_00000000_0_0badf00d
3_00000024_00000000_0_0000beef
4_30000005_41424344_8_00000003
4_30000005_41424344_4_00000003
4_30000005_41424344_2_00000003
4_30000005_41424344_1_00000003
5_00000014_00000000_0_00000044
5_00000015_00000000_0_00000043
5_00000016_00000000_0_00000042
5_00000017_00000000_0_00000041
4_30000006_61626364_c_00000003
5_0000001b_00000000_0_00000061
4_300003ff_5a000000_1_00000003
5_00000fff_00000000_0_0000005a
2_34000010_00000000_0_00000000
2_38000010_00000000_0_00000000
2_30000005_00000000_0_00000000
1_34000010_ffffffff_f_00000000
1_38000008_ffffffff_f_00000000
2_00000010_00000000_0_9966bbdd
2_3c000008_00000000_0_cafe0001
6_00000008_00000000_0_cafe0001
6_00000009_00000000_0_0badf00d
6_15000009_00000000_0_0badf00d
0_00000000_00000000_0_00000000

// ==== data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int DATA_AW = 10
) (
    input  logic                    text_mem_clk,
    mem_port_if.target              dport,
    input  mem_map_pkg::word_addr_t instr_addr,
    output mem_map_pkg::data_word_t instr_rdata
);

    localparam int DEPTH = 2 ** DATA_AW;

    mem_map_pkg::data_word_t mem [DEPTH];

    logic [DATA_AW-1:0] d_idx;
    logic [DATA_AW-1:0] i_idx;

    // low word address bits index the array
    assign d_idx = dport.addr[DATA_AW-1:0];
    assign i_idx = instr_addr[DATA_AW-1:0];

    //////////////////////////////////////////////////////////////////////
    // data port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (dport.en) begin
            if (dport.wen) begin
                // byte i of the word is enabled by bit 3-i
                for (int i = 0; i < 4; i++) begin
                    if (dport.byte_en[3-i]) begin
                        mem[d_idx][8*i +: 8] <= dport.wdata[8*i +: 8];
                    end
                end
            end
            // read-first, old word on a write
            dport.rdata <= mem[d_idx];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        instr_rdata <= mem[i_idx];
    end

endmodule

// ==== dmem_decoder.sv ====
`timescale 1ns/1ps

module dmem_decoder (
    input  logic                    text_mem_clk,
    input  logic                    rst_n,
    input  mem_map_pkg::word_addr_t instr_addr,
    input  logic                    dmem_read,
    input  logic                    dmem_write,
    input  mem_map_pkg::word_addr_t dmem_addr,
    input  mem_map_pkg::data_word_t dmem_wdata,
    input  mem_map_pkg::byte_en_t   dmem_byte_en,
    input  mem_map_pkg::word_addr_t loader_addr,
    input  mem_map_pkg::data_word_t instr_rdata_data,
    input  mem_map_pkg::data_word_t instr_rdata_loader,
    output logic                    text_req,
    mem_port_if.master              dport_data,
    mem_port_if.master              dport_loader,
    output mem_map_pkg::data_word_t instr_rdata,
    output mem_map_pkg::data_word_t dmem_rdata,
    output mem_map_pkg::data_word_t loader_rdata,
    output logic                    loader_addr_sel,
    output logic                    instr_loader_sel
);

    mem_map_pkg::region_t d_region;
    logic                 dmem_access;
    logic                 is_data;

    // state of the previous sampling edge
    logic                 rd_pending_q;
    mem_map_pkg::region_t rd_region_q;
    logic                 fetch_valid_q;
    logic                 ifetch_loader_q;
    logic                 ld_ext_q;

    //////////////////////////////////////////////////////////////////////
    // region decode
    //////////////////////////////////////////////////////////////////////

    assign d_region    = dmem_addr[mem_map_pkg::REGION_MSB:mem_map_pkg::REGION_LSB];
    assign dmem_access = dmem_read | dmem_write;
    // everything below the text region is main memory
    assign is_data     = (d_region < mem_map_pkg::REGION_TEXT);

    // text memory is write-only from the cpu side
    assign text_req         = dmem_write && (d_region == mem_map_pkg::REGION_TEXT);
    assign loader_addr_sel  = dmem_access && (d_region == mem_map_pkg::REGION_LOADER);
    assign instr_loader_sel =
        (instr_addr[mem_map_pkg::REGION_MSB:mem_map_pkg::REGION_LSB]
         == mem_map_pkg::REGION_LOADER);

    // data ram port, only touched for regions 0 to b
    assign dport_data.en      = dmem_access && is_data;
    assign dport_data.wen     = dmem_write && is_data;
    assign dport_data.addr    = dmem_addr;
    assign dport_data.wdata   = dmem_wdata;
    assign dport_data.byte_en = dmem_byte_en;

    // loader port a always reads, external address when cpu is elsewhere
    assign dport_loader.en      = 1'b1;
    assign dport_loader.wen     = loader_addr_sel && dmem_write;
    assign dport_loader.addr    = loader_addr_sel ? dmem_addr : loader_addr;
    assign dport_loader.wdata   = dmem_wdata;
    assign dport_loader.byte_en = dmem_byte_en;

    //////////////////////////////////////////////////////////////////////
    // read return
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge text_mem_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending_q    <= 1'b0;
            rd_region_q     <= '0;
            fetch_valid_q   <= 1'b0;
            ifetch_loader_q <= 1'b0;
            ld_ext_q        <= 1'b0;
        end else begin
            rd_pending_q    <= dmem_read;
            rd_region_q     <= d_region;
            // instr_addr is sampled on every edge
            fetch_valid_q   <= 1'b1;
            ifetch_loader_q <= instr_loader_sel;
            ld_ext_q        <= ~loader_addr_sel;
        end
    end

    always_comb begin
        dmem_rdata = '0;
        if (rd_pending_q) begin
            case (rd_region_q)
                mem_map_pkg::REGION_LOADER: dmem_rdata = dport_loader.rdata;
                // text, timer and keyboard read back as zero
                mem_map_pkg::REGION_TEXT,
                mem_map_pkg::REGION_TIMER,
                mem_map_pkg::REGION_KBD:    dmem_rdata = '0;
                default:                    dmem_rdata = dport_data.rdata;
            endcase
        end
    end

    // fetch word from the region registered with its address
    assign instr_rdata = !fetch_valid_q  ? '0 :
                         ifetch_loader_q ? instr_rdata_loader : instr_rdata_data;

    // external view only valid when the cpu left the loader alone
    assign loader_rdata = ld_ext_q ? dport_loader.rdata : '0;

endmodule

// ==== loader_ram.sv ====
`timescale 1ns/1ps

module loader_ram #(
    parameter int LOADER_AW = 10
) (
    input  logic                    text_mem_clk,
    mem_port_if.target              dport,
    input  mem_map_pkg::word_addr_t instr_addr,
    output mem_map_pkg::data_word_t instr_rdata
);

    localparam int DEPTH = 2 ** LOADER_AW;

    // boot image, loaded through port a
    mem_map_pkg::data_word_t mem [DEPTH];

    logic [LOADER_AW-1:0] a_idx;
    logic [LOADER_AW-1:0] b_idx;

    // low bits only, region f base maps to word 0
    assign a_idx = dport.addr[LOADER_AW-1:0];
    assign b_idx = instr_addr[LOADER_AW-1:0];

    //////////////////////////////////////////////////////////////////////
    // port a, cpu data or external loader
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge text_mem_clk) begin
        if (dport.en) begin
            // whole word writes, byte lanes not split here
            if (dport.wen) begin
                mem[a_idx] <= dport.wdata;
            end
            dport.rdata <= mem[a_idx];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // port b, instruction fetch
    //////////////////////////////////////////////////////////////////////

    // read only
    always_ff @(posedge text_mem_clk) begin
        instr_rdata <= mem[b_idx];
    end

endmodule

// ==== mem_map_pkg.sv ====
package mem_map_pkg;

    //////////////////////////////////////////////////////////////////////
    // address and data widths
    //////////////////////////////////////////////////////////////////////

    // cpu word address, region code sits in the top four bits
    typedef logic [29:0] word_addr_t;

    typedef logic [31:0] data_word_t;

    // one bit per byte, bit 3 is the lowest-addressed byte
    typedef logic [3:0] byte_en_t;

    // one text memory cell
    typedef logic [7:0] char_t;

    typedef logic [3:0] region_t;

    //////////////////////////////////////////////////////////////////////
    // memory map
    //////////////////////////////////////////////////////////////////////

    // region field position inside a word address
    localparam int REGION_MSB = 29;
    localparam int REGION_LSB = 26;

    // regions 0 to b all land in the data RAM
    localparam region_t REGION_TEXT   = 4'hc;
    // timer and keyboard are decoded only, nothing behind them
    localparam region_t REGION_TIMER  = 4'hd;
    localparam region_t REGION_KBD    = 4'he;
    localparam region_t REGION_LOADER = 4'hf;

    //////////////////////////////////////////////////////////////////////
    // text write sequencer
    //////////////////////////////////////////////////////////////////////

    // encodings double as the stall cycle count
    typedef enum logic [1:0] {
        TS_IDLE   = 2'd0,
        TS_WRITE1 = 2'd1,
        TS_WRITE2 = 2'd2,
        TS_DONE   = 2'd3
    } text_seq_state_t;

endpackage

// ==== mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;

    // access strobe, target samples on the edge where this is high
    logic                    en;
    // write when set, read otherwise
    logic                    wen;
    mem_map_pkg::word_addr_t addr;
    mem_map_pkg::data_word_t wdata;
    mem_map_pkg::byte_en_t   byte_en;
    // read word, one cycle after the sampling edge
    mem_map_pkg::data_word_t rdata;

    // decoder side
    modport master (
        output en,
        output wen,
        output addr,
        output wdata,
        output byte_en,
        input  rdata
    );

    // ram side
    modport target (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        input  byte_en,
        output rdata
    );

endinterface

// ==== tb_cpu_mem_interface.sv ====
`timescale 1ns/1ps

module tb_cpu_mem_interface;

    localparam int TEXT_AW = 12;
    localparam int MAX_OPS = 64;

    logic                    text_mem_clk = 1'b0;
    logic                    rst_n;
    mem_map_pkg::word_addr_t instr_addr;
    logic                    dmem_read;
    logic                    dmem_write;
    mem_map_pkg::word_addr_t dmem_addr;
    mem_map_pkg::data_word_t dmem_wdata;
    mem_map_pkg::byte_en_t   dmem_byte_en;
    mem_map_pkg::word_addr_t loader_addr;
    logic [TEXT_AW-1:0]      scan_addr;
    mem_map_pkg::data_word_t instr_rdata;
    mem_map_pkg::data_word_t dmem_rdata;
    logic                    mem_stall;
    mem_map_pkg::data_word_t loader_rdata;
    mem_map_pkg::char_t      scan_char;

    // op, addr, data, byte enable, expected
    logic [103:0] trace_mem [0:MAX_OPS-1];

    // shadow copies of the three memories
    logic [31:0] data_sh   [0:1023];
    logic [31:0] loader_sh [0:1023];
    logic [7:0]  text_sh   [0:4095];

    int trace_len;
    int cycle_count = 0;
    int cycle_limit = 100;

    cpu_mem_interface #(
        .TEXT_AW (TEXT_AW)
    ) dut (
        .text_mem_clk (text_mem_clk),
        .rst_n        (rst_n),
        .instr_addr   (instr_addr),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_byte_en (dmem_byte_en),
        .loader_addr  (loader_addr),
        .scan_addr    (scan_addr),
        .instr_rdata  (instr_rdata),
        .dmem_rdata   (dmem_rdata),
        .mem_stall    (mem_stall),
        .loader_rdata (loader_rdata),
        .scan_char    (scan_char)
    );

    always #20 text_mem_clk = ~text_mem_clk;

    // run limit from the trace length
    // a checker assertion failure also ends the run here
    always @(posedge text_mem_clk) begin
        cycle_count++;
        if (dut.u_checker.fail_count != 0) begin
            $display("A checker assertion failed on the previous cycle");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end else if (cycle_count >= cycle_limit) begin
            $display("Timeout: no progress within %0d clock cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic compare_values(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // d and e read as zero, text is write only
    function automatic logic [31:0] model_data_read(input logic [29:0] addr);
        if (addr[29:26] == mem_map_pkg::REGION_LOADER) begin
            return loader_sh[addr[9:0]];
        end else if (addr[29:26] >= mem_map_pkg::REGION_TEXT) begin
            return 32'h0;
        end
        return data_sh[addr[9:0]];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus operations
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input logic [29:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        @(posedge text_mem_clk);
        dmem_write   <= 1'b1;
        dmem_addr    <= addr;
        dmem_wdata   <= data;
        dmem_byte_en <= be;
        @(posedge text_mem_clk);
        dmem_write <= 1'b0;
        // loader takes whole words, data ram merges bytes
        if (addr[29:26] == mem_map_pkg::REGION_LOADER) begin
            loader_sh[addr[9:0]] = data;
        end else if (addr[29:26] < mem_map_pkg::REGION_TEXT) begin
            for (int b = 0; b < 4; b++) begin
                if (be[3-b]) begin
                    data_sh[addr[9:0]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic read_word(input logic [29:0] addr, input logic [31:0] exp);
        compare_values("dmem_rdata model vs trace", model_data_read(addr), exp);
        @(posedge text_mem_clk);
        dmem_read <= 1'b1;
        dmem_addr <= addr;
        @(posedge text_mem_clk);
        dmem_read <= 1'b0;
        @(negedge text_mem_clk);
        compare_values("dmem_rdata", dmem_rdata, exp);
    endtask

    task automatic fetch_word(input logic [29:0] addr, input logic [31:0] exp);
        logic [31:0] model;
        model = (addr[29:26] == mem_map_pkg::REGION_LOADER) ? loader_sh[addr[9:0]]
                                                             : data_sh[addr[9:0]];
        compare_values("instr_rdata model vs trace", model, exp);
        @(posedge text_mem_clk);
        instr_addr <= addr;
        @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        compare_values("instr_rdata", instr_rdata, exp);
    endtask

    // exp holds the stall length here
    task automatic write_text_char(input logic [29:0] addr, input logic [31:0] data,
                                   input logic [3:0] be, input logic [31:0] exp);
        int         stall_cycles;
        logic [1:0] lane;
        stall_cycles = 0;
        compare_values("stall length model vs trace", 32'd3, exp);
        @(posedge text_mem_clk);
        dmem_write   <= 1'b1;
        dmem_addr    <= addr;
        dmem_wdata   <= data;
        dmem_byte_en <= be;
        @(negedge text_mem_clk);
        while (mem_stall) begin
            stall_cycles++;
            @(negedge text_mem_clk);
        end
        // request held until stall drops
        @(posedge text_mem_clk);
        dmem_write <= 1'b0;
        compare_values("mem_stall cycles", stall_cycles, exp);
        case (be)
            4'b1000: lane = 2'd0;
            4'b0100: lane = 2'd1;
            4'b0010: lane = 2'd2;
            default: lane = 2'd3;
        endcase
        text_sh[{addr[9:0], lane}] = data[8*lane +: 8];
    endtask

    task automatic scan_text(input logic [29:0] addr, input logic [31:0] exp);
        compare_values("scan_char model vs trace", {24'h0, text_sh[addr[11:0]]}, exp);
        @(posedge text_mem_clk);
        scan_addr <= addr[TEXT_AW-1:0];
        @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        compare_values("scan_char", {24'h0, scan_char}, exp);
    endtask

    task automatic read_loader_ext(input logic [29:0] addr, input logic [31:0] exp);
        compare_values("loader_rdata model vs trace", loader_sh[addr[9:0]], exp);
        @(posedge text_mem_clk);
        loader_addr <= addr;
        @(posedge text_mem_clk);
        @(negedge text_mem_clk);
        compare_values("loader_rdata", loader_rdata, exp);
    endtask

    // idle cycles, unused ports wander
    task automatic idle_gap();
        int n;
        n = $urandom_range(3, 0);
        repeat (n) begin
            @(posedge text_mem_clk);
            loader_addr <= 30'($urandom);
            scan_addr   <= TEXT_AW'($urandom);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [31:0] exp;
        void'($urandom(32'hd28f_68c6));
        rst_n        = 1'b0;
        instr_addr   = '0;
        dmem_read    = 1'b0;
        dmem_write   = 1'b0;
        dmem_addr    = '0;
        dmem_wdata   = '0;
        dmem_byte_en = '0;
        loader_addr  = '0;
        scan_addr    = '0;
        // op 0 marks the end of the trace
        for (int i = 0; i < MAX_OPS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("cpu_mem_trace.txt", trace_mem);
        trace_len = 0;
        while (trace_len < MAX_OPS && trace_mem[trace_len][103:100] != 4'h0) begin
            trace_len++;
        end
        if (trace_len == 0) begin
            $display("The trace file is missing or holds no operations");
            $display("Test failed");
            $fatal(1, "no stimulus");
        end
        cycle_limit = 20 * trace_len + 100;

        repeat (4) @(posedge text_mem_clk);
        rst_n <= 1'b1;
        @(negedge text_mem_clk);
        compare_values("mem_stall", {31'h0, mem_stall}, 32'h0);
        compare_values("dmem_rdata", dmem_rdata, 32'h0);

        for (int i = 0; i < trace_len; i++) begin
            op   = trace_mem[i][103:100];
            addr = trace_mem[i][99:68];
            data = trace_mem[i][67:36];
            be   = trace_mem[i][35:32];
            exp  = trace_mem[i][31:0];
            case (op)
                4'h1: write_word(addr[29:0], data, be);
                4'h2: read_word(addr[29:0], exp);
                4'h3: fetch_word(addr[29:0], exp);
                4'h4: write_text_char(addr[29:0], data, be, exp);
                4'h5: scan_text(addr[29:0], exp);
                4'h6: read_loader_ext(addr[29:0], exp);
                default: begin
                    $display("Unknown operation code %h on trace line %0d", op, i);
                    $display("Test failed");
                    $fatal(1, "bad trace");
                end
            endcase
            idle_gap();
        end

        if (dut.u_checker.fail_count != 0) begin
            $display("Checker saw %0d assertion failures", dut.u_checker.fail_count);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== text_ram.sv ====
`timescale 1ns/1ps

module text_ram #(
    parameter int TEXT_AW = 12
) (
    input  logic                 text_mem_clk,
    input  logic [TEXT_AW-1:0]   text_addr,
    input  mem_map_pkg::char_t   text_char,
    input  logic                 text_wen,
    input  logic [TEXT_AW-1:0]   scan_addr,
    output mem_map_pkg::char_t   scan_char
);

    localparam int DEPTH = 2 ** TEXT_AW;

    // one character per byte address
    mem_map_pkg::char_t mem [DEPTH];

    // write side, held for two cycles by the sequencer
    always_ff @(posedge text_mem_clk) begin
        if (text_wen) begin
            mem[text_addr] <= text_char;
        end
    end

    // scan side stands in for the display fetch
    always_ff @(posedge text_mem_clk) begin
        scan_char <= mem[scan_addr];
    end

endmodule

// ==== text_write_sequencer.sv ====
`timescale 1ns/1ps

module text_write_sequencer #(
    parameter int TEXT_AW = 12
) (
    input  logic                    text_mem_clk,
    input  logic                    rst_n,
    input  logic                    text_req,
    input  mem_map_pkg::word_addr_t dmem_addr,
    input  mem_map_pkg::byte_en_t   dmem_byte_en,
    input  mem_map_pkg::data_word_t dmem_wdata,
    output logic                    mem_stall,
    output logic [TEXT_AW-1:0]      text_addr,
    output mem_map_pkg::char_t      text_char,
    output logic                    text_wen
);

    mem_map_pkg::text_seq_state_t state_q;
    mem_map_pkg::text_seq_state_t state_d;

    // byte within the word
    logic [1:0] lane;

    //////////////////////////////////////////////////////////////////////
    // stall fsm
    //////////////////////////////////////////////////////////////////////

    // goes high in the request cycle itself, drops at TS_DONE
    assign mem_stall = text_req && (state_q != mem_map_pkg::TS_DONE);

    always_comb begin
        state_d = state_q;
        if (!text_req) begin
            // request gone, back to idle
            state_d = mem_map_pkg::TS_IDLE;
        end else if (state_q != mem_map_pkg::TS_DONE) begin
            // one step per cycle, then spin in TS_DONE
            state_d = mem_map_pkg::text_seq_state_t'(state_q + 2'd1);
        end
    end

    always_ff @(posedge text_mem_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mem_map_pkg::TS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // two write cycles, addr and char steady since cpu is stalled
    assign text_wen = (state_q == mem_map_pkg::TS_WRITE1) ||
                      (state_q == mem_map_pkg::TS_WRITE2);

    //////////////////////////////////////////////////////////////////////
    // byte lane and character
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (dmem_byte_en)
            4'b1000: lane = 2'd0;
            4'b0100: lane = 2'd1;
            4'b0010: lane = 2'd2;
            4'b0001: lane = 2'd3;
            // not one-hot, use the top byte
            default: lane = 2'd3;
        endcase
    end

    assign text_addr = {dmem_addr[TEXT_AW-3:0], lane};
    assign text_char = dmem_wdata[8*lane +: 8];

endmodule
